// ==== list.f ====
+incdir+src
src/axi_pkg.sv
src/icache_pkg.sv
src/icache_line_store.sv
src/icache_ctrl.sv
src/inst_rom.sv
src/fetch_cache_top.sv
verification/tb_fetch_cache.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f list.f --top-module tb_fetch_cache \
    --Mdir obj_dir -o sim_tb_fetch_cache
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb_fetch_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== src/rom.hex ====
// one 32-bit instruction word per line, word addresses 0 to 31
00000013
00500093
00a00113
002081b3
40208233
0030f2b3
0041e333
005243b3
00209413
0020d493
00100513
00b50023
00052583
fe050ee3
00158593
00c000ef
0ff00613
00361693
40365713
00d707b3
00f02223
00402803
01080863
fff88893
00088463
0140006f
00008067
30200073
10500073
0000100f
00000073
00100073

// ==== verification/tb_fetch_cache.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module tb_fetch_cache;
    import axi_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int RANDOM_FETCHES = 300;
    localparam int ROM_IDX_BITS   = $clog2(`ROM_WORDS);

    logic                       clk;
    logic                       rst_n;
    logic [`AXI_ADDR_WIDTH-1:0] core_araddr;
    logic                       core_arvalid;
    logic                       core_arready;
    logic [`AXI_DATA_WIDTH-1:0] core_rdata;
    axi_resp_t                  core_rresp;
    logic                       core_rvalid;
    logic                       core_rready;

    // reference copy of the image plus tag/valid shadow
    logic [`AXI_DATA_WIDTH-1:0] rom_model [`ROM_WORDS];
    logic [`ICACHE_TAG_BITS-1:0] tag_model [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]   valid_model;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int hits_seen;
    bit timed_out;

    fetch_cache_top fetch_cache_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_araddr  (core_araddr),
        .core_arvalid (core_arvalid),
        .core_arready (core_arready),
        .core_rdata   (core_rdata),
        .core_rresp   (core_rresp),
        .core_rvalid  (core_rvalid),
        .core_rready  (core_rready)
    );

    always #2 clk = ~clk;

    task automatic expect_true(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("[ERROR] %0t ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before, input string note);
        bit failed;
        failed = (errors != err_before) || timed_out;
        tests_run++;
        if (failed) tests_failed++;
        $display("test %s %s %s", name, failed ? "failed" : "passed", note);
    endtask

    function automatic logic [`AXI_ADDR_WIDTH-1:0] random_fetch_addr();
        logic [`AXI_ADDR_WIDTH-1:0] a;
        a = ($urandom_range(63, 0) << 2) | $urandom_range(3, 0);  // 0x00..0xff
        return a;
    endfunction

    // one complete core read, checked against the model; ends at posedge + 1
    task automatic fetch(input logic [`AXI_ADDR_WIDTH-1:0] addr, input int max_stall,
                         output bit answered_hit);
        logic [`ICACHE_INDEX_BITS-1:0] idx;
        logic [`ICACHE_TAG_BITS-1:0]   tag;
        logic [`AXI_DATA_WIDTH-1:0]    exp_data;
        logic [`AXI_DATA_WIDTH-1:0]    held_data;
        axi_resp_t                     exp_resp;
        axi_resp_t                     held_resp;
        bit                            predicted_hit;
        int                            cyc;
        int                            waited;
        int                            stall;

        answered_hit = 1'b0;
        idx = addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
        tag = addr[`AXI_ADDR_WIDTH-1 -: `ICACHE_TAG_BITS];
        if ((addr >> 2) < `ROM_WORDS) begin
            exp_data = rom_model[addr[ROM_IDX_BITS+1:2]];
            exp_resp = OKAY;
        end else begin
            exp_data = '0;
            exp_resp = SLVERR;
        end
        predicted_hit = valid_model[idx] && (tag_model[idx] == tag);
        stall = int'($urandom_range(max_stall, 0));
        if (timed_out) return;

        core_araddr  = addr;
        core_arvalid = 1'b1;
        core_rready  = 1'b0;
        waited = 0;
        while (!core_arready && !timed_out) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                $display("timeout: the cache never became ready for address 0x%08h", addr);
                timed_out = 1'b1;
            end
        end
        if (timed_out) return;

        @(posedge clk);  // accepting edge
        #1;
        core_arvalid = 1'b0;
        cyc = 1;
        while (!core_rvalid && !timed_out) begin
            expect_true(!core_arready, $sformatf("arready high with 0x%08h open", addr));
            @(posedge clk);
            #1;
            cyc++;
            if (cyc > TIMEOUT_CYCLES) begin
                $display("timeout: no read data came back for address 0x%08h", addr);
                timed_out = 1'b1;
            end
        end
        if (timed_out) return;
        answered_hit = (cyc == 2);

        if (predicted_hit) begin
            hits_seen++;
            expect_true(cyc == 2, $sformatf("hit 0x%08h answered in cycle %0d, not 2", addr, cyc));
        end else begin
            expect_true(cyc > 2, $sformatf("miss 0x%08h answered in cycle %0d", addr, cyc));
        end
        expect_true(core_rdata == exp_data,
            $sformatf("rdata 0x%08h for 0x%08h, expected 0x%08h", core_rdata, addr, exp_data));
        expect_true(core_rresp == exp_resp,
            $sformatf("rresp %0d for 0x%08h, expected %0d", core_rresp, addr, exp_resp));

        held_data = core_rdata;
        held_resp = core_rresp;
        repeat (stall) begin
            @(posedge clk);
            #1;
            expect_true(core_rvalid && !core_arready,
                $sformatf("R handshake state moved while stalled on 0x%08h", addr));
            expect_true(core_rdata == held_data && core_rresp == held_resp,
                $sformatf("R payload changed while stalled on 0x%08h", addr));
        end
        core_rready = 1'b1;
        @(posedge clk);
        #1;
        core_rready = 1'b0;
        expect_true(!core_rvalid && core_arready,
            $sformatf("cache not idle after the R transfer of 0x%08h", addr));

        if (exp_resp == OKAY) begin  // errors never allocate
            valid_model[idx] = 1'b1;
            tag_model[idx]   = tag;
        end
    endtask

    initial begin
        logic [`AXI_ADDR_WIDTH-1:0] addr_a;
        logic [`AXI_ADDR_WIDTH-1:0] addr_b;
        bit                         was_hit;
        int                         err_before;

        clk          = 1'b0;
        rst_n        = 1'b0;
        core_araddr  = '0;
        core_arvalid = 1'b0;
        core_rready  = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        hits_seen    = 0;
        timed_out    = 1'b0;
        valid_model  = '0;
        void'($urandom(6006));
        $readmemh("src/rom.hex", rom_model);

        // reset
        err_before = errors;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        expect_true(core_arready, "arready low after reset");
        expect_true(!core_rvalid, "rvalid high after reset");
        report_test("reset", err_before, "");

        err_before = errors;
        for (int i = 0; i < RANDOM_FETCHES; i++) begin
            fetch(random_fetch_addr(), 3, was_hit);
        end
        report_test("random_fetch", err_before,
            $sformatf("(%0d hits in %0d fetches)", hits_seen, RANDOM_FETCHES));

        // same index, tags 0 and 1
        err_before = errors;
        addr_a = 32'h18 | $urandom_range(3, 0);
        addr_b = addr_a + 32'h40;
        fetch(addr_b, 0, was_hit);
        for (int i = 0; i < 6; i++) begin
            fetch((i % 2 == 0) ? addr_a : addr_b, 1, was_hit);
            expect_true(!was_hit, "cache hit on an evicted line");
        end
        report_test("eviction", err_before, "");

        err_before = errors;
        for (int i = 0; i < 4; i++) begin
            addr_a = 32'h80 + ($urandom_range(31, 0) << 2);
            fetch(addr_a, 1, was_hit);
            fetch(addr_a, 1, was_hit);
            expect_true(!was_hit, "cache hit on an SLVERR address");
        end
        report_test("error_no_alloc", err_before, "");

        err_before = errors;
        for (int i = 0; i < 40; i++) begin
            fetch(random_fetch_addr(), 8, was_hit);  // long stalls
        end
        report_test("back_pressure", err_before, "");

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
            tests_run, tests_failed, checks, errors);
        if (tests_failed == 0 && errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/fetch_cache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module fetch_cache_top (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic [`AXI_ADDR_WIDTH-1:0]  core_araddr,
    input  logic                        core_arvalid,
    output logic                        core_arready,

    output logic [`AXI_DATA_WIDTH-1:0]  core_rdata,
    output axi_pkg::axi_resp_t          core_rresp,
    output logic                        core_rvalid,
    input  logic                        core_rready
);
    import axi_pkg::*;
    import icache_pkg::*;

    // cache to rom
    logic [`AXI_ADDR_WIDTH-1:0] mem_araddr;
    logic                       mem_arvalid;
    logic                       mem_arready;
    logic [`AXI_DATA_WIDTH-1:0] mem_rdata;
    axi_resp_t                  mem_rresp;
    logic                       mem_rvalid;
    logic                       mem_rready;

    // controller to line store
    fetch_addr_t                lookup_addr;
    logic                       fill_en;
    logic [`AXI_DATA_WIDTH-1:0] fill_data;
    logic                       hit;
    logic [`AXI_DATA_WIDTH-1:0] hit_data;

    icache_ctrl icache_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_araddr  (core_araddr),
        .core_arvalid (core_arvalid),
        .core_arready (core_arready),
        .core_rdata   (core_rdata),
        .core_rresp   (core_rresp),
        .core_rvalid  (core_rvalid),
        .core_rready  (core_rready),
        .mem_araddr   (mem_araddr),
        .mem_arvalid  (mem_arvalid),
        .mem_arready  (mem_arready),
        .mem_rdata    (mem_rdata),
        .mem_rresp    (mem_rresp),
        .mem_rvalid   (mem_rvalid),
        .mem_rready   (mem_rready),
        .lookup_addr  (lookup_addr),
        .fill_en      (fill_en),
        .fill_data    (fill_data),
        .hit          (hit),
        .hit_data     (hit_data)
    );

    icache_line_store icache_line_store_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en),
        .fill_data   (fill_data),
        .hit         (hit),
        .hit_data    (hit_data)
    );

    inst_rom inst_rom_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_araddr  (mem_araddr),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_rdata   (mem_rdata),
        .mem_rresp   (mem_rresp),
        .mem_rvalid  (mem_rvalid),
        .mem_rready  (mem_rready)
    );

endmodule

`default_nettype wire

// ==== src/inst_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module inst_rom (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic [`AXI_ADDR_WIDTH-1:0]  mem_araddr,
    input  logic                        mem_arvalid,
    output logic                        mem_arready,

    output logic [`AXI_DATA_WIDTH-1:0]  mem_rdata,
    output axi_pkg::axi_resp_t          mem_rresp,
    output logic                        mem_rvalid,
    input  logic                        mem_rready
);
    import axi_pkg::*;

    localparam int IDX_BITS = $clog2(`ROM_WORDS);
    localparam int CNT_BITS = $clog2(`ROM_WAIT_CYCLES + 1);

    localparam logic [1:0] R_IDLE = 2'd0;
    localparam logic [1:0] R_WAIT = 2'd1;
    localparam logic [1:0] R_RESP = 2'd2;

    logic [`AXI_DATA_WIDTH-1:0] rom [`ROM_WORDS];
    logic [1:0]                 state;
    logic [CNT_BITS-1:0]        cnt;
    logic [`AXI_ADDR_WIDTH-1:0] addr_q;
    logic                       in_range;

    initial $readmemh("src/rom.hex", rom);

    // word address against image size, offset bits dropped
    assign in_range = (addr_q[`AXI_ADDR_WIDTH-1:2] < `ROM_WORDS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= R_IDLE;
            mem_arready <= 1'b0;
            mem_rvalid  <= 1'b0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (mem_arvalid && mem_arready) begin
                        addr_q      <= mem_araddr;
                        cnt         <= CNT_BITS'(`ROM_WAIT_CYCLES - 1);
                        mem_arready <= 1'b0;
                        state       <= R_WAIT;
                    end else if (mem_arvalid) begin
                        mem_arready <= 1'b1;  // accept one cycle later
                    end
                end
                R_WAIT: begin
                    if (cnt <= 1) begin
                        mem_rvalid <= 1'b1;
                        mem_rdata  <= in_range ? rom[addr_q[IDX_BITS+1:2]] : '0;
                        mem_rresp  <= in_range ? OKAY : SLVERR;
                        state      <= R_RESP;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                R_RESP: begin
                    if (mem_rready) begin
                        mem_rvalid <= 1'b0;
                        state      <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // every response traces back to an AR handshake a fixed time earlier
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_rvalid) |-> $past(mem_arvalid && mem_arready, `ROM_WAIT_CYCLES))
        else $error("rom rvalid without an accepted address");

endmodule

`default_nettype wire

// ==== src/icache_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,

    // core side, AR
    input  logic [`AXI_ADDR_WIDTH-1:0]  core_araddr,
    input  logic                        core_arvalid,
    output logic                        core_arready,
    // core side, R
    output logic [`AXI_DATA_WIDTH-1:0]  core_rdata,
    output axi_pkg::axi_resp_t          core_rresp,
    output logic                        core_rvalid,
    input  logic                        core_rready,

    // memory side, AR
    output logic [`AXI_ADDR_WIDTH-1:0]  mem_araddr,
    output logic                        mem_arvalid,
    input  logic                        mem_arready,
    // memory side, R
    input  logic [`AXI_DATA_WIDTH-1:0]  mem_rdata,
    input  axi_pkg::axi_resp_t          mem_rresp,
    input  logic                        mem_rvalid,
    output logic                        mem_rready,

    // line store
    output icache_pkg::fetch_addr_t     lookup_addr,
    output logic                        fill_en,
    output logic [`AXI_DATA_WIDTH-1:0]  fill_data,
    input  logic                        hit,
    input  logic [`AXI_DATA_WIDTH-1:0]  hit_data
);
    import axi_pkg::*;

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_LOOKUP = 2'd1;
    localparam logic [1:0] S_REFILL = 2'd2;
    localparam logic [1:0] S_RETURN = 2'd3;

    localparam logic [1:0] M_IDLE = 2'd0;
    localparam logic [1:0] M_ADDR = 2'd1;
    localparam logic [1:0] M_WAIT = 2'd2;

    logic [1:0]                 state;
    logic [1:0]                 mem_state;
    logic [`AXI_DATA_WIDTH-1:0] rdata_q;
    axi_resp_t                  rresp_q;
    logic                       r_done;
    logic                       refill_err;

    assign core_arready = (state == S_IDLE);
    assign core_rvalid  = (state == S_RETURN);
    assign core_rdata   = rdata_q;
    assign core_rresp   = rresp_q;
    assign mem_araddr   = lookup_addr.raw;

    assign r_done     = mem_rvalid && mem_rready;
    assign fill_en    = r_done && (mem_rresp == OKAY);
    assign refill_err = r_done && (mem_rresp != OKAY);  // never allocated
    assign fill_data  = mem_rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (core_arvalid) state <= S_LOOKUP;
                S_LOOKUP: state <= hit ? S_RETURN : S_REFILL;
                S_REFILL: if (hit || refill_err) state <= S_RETURN;
                S_RETURN: if (core_rready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (state == S_IDLE && core_arvalid) begin
            lookup_addr.raw <= core_araddr;
        end
        if ((state == S_LOOKUP || state == S_REFILL) && hit) begin
            rdata_q <= hit_data;
            rresp_q <= OKAY;
        end else if (state == S_REFILL && refill_err) begin
            rdata_q <= mem_rdata;
            rresp_q <= mem_rresp;
        end
    end

    // refill engine
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_state   <= M_IDLE;
            mem_arvalid <= 1'b0;
            mem_rready  <= 1'b0;
        end else begin
            case (mem_state)
                M_IDLE: begin
                    if (state == S_LOOKUP && !hit) begin
                        mem_arvalid <= 1'b1;
                        mem_state   <= M_ADDR;
                    end
                end
                M_ADDR: begin
                    if (mem_arready) begin
                        mem_arvalid <= 1'b0;
                        mem_rready  <= 1'b1;  // held high for the whole wait
                        mem_state   <= M_WAIT;
                    end
                end
                M_WAIT: begin
                    if (mem_rvalid) begin
                        mem_rready <= 1'b0;
                        mem_state  <= M_IDLE;
                    end
                end
                default: mem_state <= M_IDLE;
            endcase
        end
    end

    // refill engine quiet whenever a new request can be taken
    assert property (@(posedge clk) disable iff (!rst_n)
        core_arready |-> (mem_state == M_IDLE) && !mem_arvalid && !mem_rready)
        else $error("refill traffic while the cache is idle");

    assert property (@(posedge clk) disable iff (!rst_n)
        core_rvalid && !core_rready |=>
            core_rvalid && $stable(core_rdata) && $stable(core_rresp))
        else $error("core R channel changed under back-pressure");

    assert property (@(posedge clk) disable iff (!rst_n)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
        else $error("mem arvalid dropped before handshake");

endmodule

`default_nettype wire

// ==== src/icache_line_store.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_line_store (
    input  logic                        clk,
    input  logic                        rst_n,

    input  icache_pkg::fetch_addr_t     lookup_addr,
    input  logic                        fill_en,
    input  logic [`AXI_DATA_WIDTH-1:0]  fill_data,

    output logic                        hit,
    output logic [`AXI_DATA_WIDTH-1:0]  hit_data
);
    import icache_pkg::*;

    logic [`AXI_DATA_WIDTH-1:0] data_array [`ICACHE_LINES];
    icache_tag_t                tag_array  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]   valid_array;

    icache_index_t index;
    icache_tag_t   tag;

    assign index = lookup_addr.fields.index;
    assign tag   = lookup_addr.fields.tag;

    assign hit      = valid_array[index] && (tag_array[index] == tag);
    assign hit_data = data_array[index];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_array <= '0;
        end else if (fill_en) begin
            valid_array[index] <= 1'b1;
        end
    end

    // data and tag go in with the valid bit, same edge
    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_array[index] <= fill_data;
            tag_array[index]  <= tag;
        end
    end

    // controller holds the address through the fill, so the
    // recheck one cycle later has to see the new line
    assert property (@(posedge clk) disable iff (!rst_n)
        fill_en |=> hit)
        else $error("line fill not visible on recheck");

endmodule

`default_nettype wire

// ==== src/icache_pkg.sv ====
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

    typedef logic [`ICACHE_TAG_BITS-1:0]   icache_tag_t;
    typedef logic [`ICACHE_INDEX_BITS-1:0] icache_index_t;

    typedef struct packed {
        icache_tag_t                      tag;
        icache_index_t                    index;
        logic [`ICACHE_OFFSET_BITS-1:0]   offset; // byte in word, ignored
    } fetch_fields_t;

    // raw view goes on the bus, field view feeds the lookup
    typedef union packed {
        logic [`AXI_ADDR_WIDTH-1:0] raw;
        fetch_fields_t              fields;
    } fetch_addr_t;

endpackage

`default_nettype wire

// ==== src/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    // read response codes used on both ports
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

endpackage

`default_nettype wire

// ==== src/icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// bus widths
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32

// direct mapped, one word per line
`define ICACHE_OFFSET_BITS 2
`define ICACHE_INDEX_BITS 4
`define ICACHE_TAG_BITS (`AXI_ADDR_WIDTH - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS)
`define ICACHE_LINES (1 << `ICACHE_INDEX_BITS)

// instruction image
`define ROM_WORDS 32

// cycles from AR accept to rvalid
`define ROM_WAIT_CYCLES 3

`endif
